// ==== verilog/axi_lite_pkg.sv ====
// AXI-Lite side types shared by the request queue and the flit serializer
// import where AXI addresses, data or queued request entries are handled
`default_nettype none

package axi_lite_pkg;

    typedef logic [63:0] axi_addr_t;   // byte address from the manager
    typedef logic [63:0] axi_data_t;
    typedef logic [7:0]  axi_strb_t;   // one bit per data byte

    // kind of request sitting at the head of the type FIFO
    typedef enum logic [1:0] {
        req_inval = 2'd0,
        req_load  = 2'd1,
        req_store = 2'd2
    } req_kind_t;

    // a store once both its AW and W beats have arrived
    typedef struct packed {
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } write_req_t;

endpackage

`default_nettype wire

// ==== verilog/noc_pkg.sv ====
// Flit layouts and message codes of the packet NoC request link
// header structs are ordered msb first so they cast straight onto a flit
`default_nettype none

package noc_pkg;

    typedef logic [63:0] noc_flit_t;
    typedef logic [7:0]  msg_type_t;

    typedef struct packed {
        logic [13:0] chipid;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [3:0]  fbits;   // port select inside the tile
    } node_id_t;

    // first header, routed by the network
    typedef struct packed {
        node_id_t    dest;
        logic [7:0]  length;   // flits that follow this one
        msg_type_t   mtype;
        logic [7:0]  mshrid;
        logic [5:0]  options;
    } hdr1_t;

    typedef struct packed {
        logic [4:0]  rsvd;
        logic [2:0]  data_size;
        logic [7:0]  mask;
        logic [47:0] addr;
    } hdr2_t;

    typedef struct packed {
        node_id_t    src;
        logic [29:0] rsvd;
    } hdr3_t;

    localparam msg_type_t   msg_nc_load_req  = 8'd14;
    localparam msg_type_t   msg_nc_store_req = 8'd15;
    localparam logic [2:0]  data_size_8b     = 3'b100;
    localparam int unsigned hdr_flits        = 3;
    localparam int unsigned noc_addr_width   = 48;

endpackage

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
// Single-clock FIFO whose head word is visible without a read strobe
// push when full and pop when empty are dropped
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int width           = 64,
    parameter int fifo_depth_log2 = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [width-1:0] wdata,
    input  logic             pop,
    output logic [width-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int depth = 1 << fifo_depth_log2;

    logic [width-1:0]         mem [depth];
    logic [fifo_depth_log2:0] wr_ptr;   // msb is the wrap bit
    logic [fifo_depth_log2:0] rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    // same slot, opposite wrap bits
    assign full  = (wr_ptr[fifo_depth_log2] != rd_ptr[fifo_depth_log2]) &&
                   (wr_ptr[fifo_depth_log2-1:0] == rd_ptr[fifo_depth_log2-1:0]);
    assign rdata = mem[rd_ptr[fifo_depth_log2-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[fifo_depth_log2-1:0]] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axi_request_queue.sv ====
// Accepts AXI-Lite AW, W and AR beats and queues them in arrival order
// presents the oldest complete request to the flit serializer
`timescale 1ns/1ps
`default_nettype none

module axi_request_queue #(
    parameter int fifo_depth_log2 = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  axi_lite_pkg::axi_addr_t  awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  axi_lite_pkg::axi_data_t  wdata,
    input  axi_lite_pkg::axi_strb_t  wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    input  axi_lite_pkg::axi_addr_t  araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output axi_lite_pkg::req_kind_t  head_kind,
    output axi_lite_pkg::write_req_t head_write,
    output axi_lite_pkg::axi_addr_t  head_raddr,
    output logic                     head_ready,
    input  logic                     req_done
);

    import axi_lite_pkg::*;

    localparam int kind_w  = $bits(req_kind_t);
    localparam int wdata_w = $bits(axi_data_t) + $bits(axi_strb_t);

    logic               aw_fire;
    logic               w_fire;
    logic               ar_fire;
    logic               defer_q;   // load type still owed to the type FIFO
    logic               defer_push;

    logic               type_push;
    req_kind_t          type_wdata;
    logic [kind_w-1:0]  type_rdata;
    logic               type_full;
    logic               type_empty;

    axi_addr_t          aw_rdata;
    logic               aw_full;
    logic               aw_empty;
    logic [wdata_w-1:0] wd_rdata;
    logic               wd_full;
    logic               wd_empty;
    logic               ar_full;
    logic               ar_empty;

    logic               pop_store;
    logic               pop_load;

    assign awready = !aw_full && !type_full && !defer_q;
    assign wready  = !wd_full && !type_full;
    assign arready = !ar_full && !type_full && !defer_q;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // held load goes in as soon as the type FIFO has room
    assign defer_push = defer_q && !type_full;
    assign type_push  = aw_fire || ar_fire || defer_push;
    assign type_wdata = aw_fire ? req_store : req_load;   // store wins a joint accept

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            defer_q <= 1'b0;
        end else if (aw_fire && ar_fire) begin
            defer_q <= 1'b1;
        end else if (defer_push) begin
            defer_q <= 1'b0;
        end
    end

    assign head_kind = req_kind_t'(type_rdata);

    always_comb begin
        case (head_kind)
            req_store: head_ready = !type_empty && !aw_empty && !wd_empty;
            req_load:  head_ready = !type_empty && !ar_empty;
            default:   head_ready = 1'b0;
        endcase
    end

    // finished request releases its own operands only
    assign pop_store = req_done && (head_kind == req_store);
    assign pop_load  = req_done && (head_kind == req_load);

    assign head_write.addr = aw_rdata;
    assign head_write.data = wd_rdata[wdata_w-1:$bits(axi_strb_t)];
    assign head_write.strb = wd_rdata[$bits(axi_strb_t)-1:0];

    sync_fifo #(.width(kind_w), .fifo_depth_log2(fifo_depth_log2)) type_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(type_push), .wdata(type_wdata), .pop(req_done),
        .rdata(type_rdata), .full(type_full), .empty(type_empty)
    );

    sync_fifo #(.width($bits(axi_addr_t)), .fifo_depth_log2(fifo_depth_log2)) awaddr_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(aw_fire), .wdata(awaddr), .pop(pop_store),
        .rdata(aw_rdata), .full(aw_full), .empty(aw_empty)
    );

    sync_fifo #(.width(wdata_w), .fifo_depth_log2(fifo_depth_log2)) wdata_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(w_fire), .wdata({wdata, wstrb}), .pop(pop_store),
        .rdata(wd_rdata), .full(wd_full), .empty(wd_empty)
    );

    sync_fifo #(.width($bits(axi_addr_t)), .fifo_depth_log2(fifo_depth_log2)) araddr_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(ar_fire), .wdata(araddr), .pop(pop_load),
        .rdata(head_raddr), .full(ar_full), .empty(ar_empty)
    );

endmodule

`default_nettype wire

// ==== verilog/flit_serializer.sv ====
// Turns the queued head request into a NoC message, one flit per accepted cycle
// loads are three header flits, stores add one data flit
`timescale 1ns/1ps
`default_nettype none

module flit_serializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  axi_lite_pkg::req_kind_t  head_kind,
    input  axi_lite_pkg::write_req_t head_write,
    input  axi_lite_pkg::axi_addr_t  head_raddr,
    input  logic                     head_ready,
    output logic                     req_done,
    input  noc_pkg::node_id_t        src_id,
    input  noc_pkg::node_id_t        dest_id,
    output logic                     noc_valid,
    output noc_pkg::noc_flit_t       noc_data,
    input  logic                     noc_ready
);

    import axi_lite_pkg::*;
    import noc_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_data
    } state_t;

    state_t     state_q;
    logic [1:0] flit_cnt_q;   // header flit index
    logic       is_store;
    logic       flit_fire;
    logic       last_hdr;
    axi_addr_t  msg_addr;
    axi_strb_t  strb_rev;
    noc_flit_t  data_flit;
    hdr1_t      hdr1;
    hdr2_t      hdr2;
    hdr3_t      hdr3;

    assign is_store  = (head_kind == req_store);
    assign flit_fire = noc_valid && noc_ready;
    assign last_hdr  = (state_q == st_header) && (flit_cnt_q == 2'(hdr_flits - 1));
    assign req_done  = flit_fire && ((last_hdr && !is_store) || (state_q == st_data));

    assign msg_addr  = is_store ? head_write.addr : head_raddr;
    assign strb_rev  = {<<{head_write.strb}};   // lane 0 lands in the mask msb
    assign data_flit = {<<8{head_write.data}};  // NoC side is big endian

    always_comb begin
        hdr1        = '0;
        hdr1.dest   = dest_id;
        // two more headers, plus the data flit on a store
        hdr1.length = is_store ? 8'(hdr_flits) : 8'(hdr_flits - 1);
        hdr1.mtype  = is_store ? msg_nc_store_req : msg_nc_load_req;

        hdr2           = '0;
        hdr2.addr      = msg_addr[noc_addr_width-1:0];
        hdr2.data_size = data_size_8b;
        hdr2.mask      = is_store ? strb_rev : '0;

        hdr3     = '0;
        hdr3.src = src_id;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            flit_cnt_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (head_ready) begin
                        state_q    <= st_header;
                        flit_cnt_q <= '0;
                    end
                end
                st_header: begin
                    if (flit_fire && last_hdr) begin
                        if (is_store) begin
                            state_q <= st_data;
                        end else begin
                            state_q <= st_idle;
                        end
                    end else if (flit_fire) begin
                        flit_cnt_q <= flit_cnt_q + 1'b1;
                    end
                end
                st_data: begin
                    if (flit_fire) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    assign noc_valid = (state_q != st_idle);

    // head entry is not popped until req_done, so the flit holds under back-pressure
    always_comb begin
        case (state_q)
            st_header: begin
                case (flit_cnt_q)
                    2'd0:    noc_data = hdr1;
                    2'd1:    noc_data = hdr2;
                    default: noc_data = hdr3;
                endcase
            end
            st_data: noc_data = data_flit;
            default: noc_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/axilite_noc_bridge.sv ====
// AXI-Lite manager to packet NoC request bridge, request direction only
// set fifo_depth_log2 to size every request FIFO
`timescale 1ns/1ps
`default_nettype none

module axilite_noc_bridge #(
    parameter int fifo_depth_log2 = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axi_lite_pkg::axi_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_lite_pkg::axi_data_t wdata,
    input  axi_lite_pkg::axi_strb_t wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    input  axi_lite_pkg::axi_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    input  noc_pkg::node_id_t       src_id,
    input  noc_pkg::node_id_t       dest_id,   // fixed memory-controller tile
    output logic                    noc_valid,
    output noc_pkg::noc_flit_t      noc_data,
    input  logic                    noc_ready
);

    import axi_lite_pkg::*;

    req_kind_t  head_kind;
    write_req_t head_write;
    axi_addr_t  head_raddr;
    logic       head_ready;
    logic       req_done;   // last flit accepted, pops the head

    axi_request_queue #(.fifo_depth_log2(fifo_depth_log2)) u_queue (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .head_kind(head_kind), .head_write(head_write), .head_raddr(head_raddr),
        .head_ready(head_ready), .req_done(req_done)
    );

    flit_serializer u_serializer (
        .clk(clk), .rst_n(rst_n),
        .head_kind(head_kind), .head_write(head_write), .head_raddr(head_raddr),
        .head_ready(head_ready), .req_done(req_done),
        .src_id(src_id), .dest_id(dest_id),
        .noc_valid(noc_valid), .noc_data(noc_data), .noc_ready(noc_ready)
    );

endmodule

`default_nettype wire

// ==== bench/bridge_tb.sv ====
// Testbench for the AXI-Lite to NoC request bridge
// drives AXI-Lite requests and checks every NoC flit against a reference model
`timescale 1ns/1ps
`default_nettype none

module bridge_tb;

    import axi_lite_pkg::*;
    import noc_pkg::*;

    localparam int max_cycles = 4000;   // tests need about 1500

    logic      clk;
    logic      rst_n;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    node_id_t  src_id;
    node_id_t  dest_id;
    logic      noc_valid;
    noc_flit_t noc_data;
    logic      noc_ready;

    // reference model filled on every accepted AXI beat
    req_kind_t   kind_q[$];
    axi_addr_t   aw_q[$];
    logic [71:0] w_q[$];     // data above strobe
    axi_addr_t   ar_q[$];
    noc_flit_t   exp_q[$];   // flits of the message being sent
    int          cycles;
    int          ready_mode; // 0 low, 1 high, 2 random
    logic        stall_q;
    noc_flit_t   held_q;
    string       test_name;

    axilite_noc_bridge #(.fifo_depth_log2(2)) axilite_noc_bridge_i (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .src_id(src_id), .dest_id(dest_id),
        .noc_valid(noc_valid), .noc_data(noc_data), .noc_ready(noc_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        case (ready_mode)
            0:       noc_ready = 1'b0;
            1:       noc_ready = 1'b1;
            default: noc_ready = 1'($urandom % 2);
        endcase
    end

    task automatic fail_plain(input string msg);
        $display(">>> FAIL");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        fail_plain($sformatf("error %s (%s): expected %h, actual %h",
                             test_name, what, expected, actual));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            fail_plain("run did not finish within the cycle limit");
        end
    end

    // lane 0 of the strobe ends up in the mask msb
    function automatic axi_strb_t reverse_strobe(input axi_strb_t s);
        axi_strb_t r;
        for (int i = 0; i < 8; i++) begin
            r[7-i] = s[i];
        end
        return r;
    endfunction

    function automatic noc_flit_t reverse_bytes(input axi_data_t d);
        noc_flit_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*(7-i) +: 8] = d[8*i +: 8];
        end
        return r;
    endfunction

    // expected flits of the oldest accepted request
    task automatic build_message();
        req_kind_t   k;
        hdr1_t       h1;
        hdr2_t       h2;
        hdr3_t       h3;
        axi_addr_t   a;
        logic [71:0] dw;
        k  = kind_q.pop_front();
        h1 = '0;
        h2 = '0;
        h3 = '0;
        h1.dest      = dest_id;
        h3.src       = src_id;
        h2.data_size = data_size_8b;
        if (k == req_store) begin
            a  = aw_q.pop_front();
            dw = w_q.pop_front();
            h1.length = 8'd3;
            h1.mtype  = msg_nc_store_req;
            h2.mask   = reverse_strobe(dw[7:0]);
        end else begin
            a = ar_q.pop_front();
            h1.length = 8'd2;
            h1.mtype  = msg_nc_load_req;
        end
        h2.addr = a[47:0];
        exp_q.push_back(h1);
        exp_q.push_back(h2);
        exp_q.push_back(h3);
        if (k == req_store) begin
            exp_q.push_back(reverse_bytes(dw[71:8]));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (awvalid && awready) begin
                kind_q.push_back(req_store);
                aw_q.push_back(awaddr);
            end
            if (arvalid && arready) begin   // after the store on a joint accept
                kind_q.push_back(req_load);
                ar_q.push_back(araddr);
            end
            if (wvalid && wready) begin
                w_q.push_back({wdata, wstrb});
            end
            if (noc_valid && noc_ready) begin
                if (exp_q.size() == 0 && kind_q.size() != 0) begin
                    build_message();
                end
                assert (exp_q.size() != 0)
                else fail_plain("a flit was sent with no request outstanding");
                assert (noc_data == exp_q[0]) else fail_value("flit", exp_q[0], noc_data);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        stall_q <= rst_n && noc_valid && !noc_ready;
        held_q  <= noc_data;
    end

    always @(negedge clk) begin
        if (stall_q) begin
            assert (noc_valid)
            else fail_plain("noc_valid dropped while a flit was stalled");
            assert (noc_data == held_q) else fail_value("held flit", held_q, noc_data);
        end
    end

    task automatic drive_request(input logic aw, input logic w, input logic ar,
                                 input axi_addr_t a, input axi_data_t d,
                                 input axi_strb_t s, input axi_addr_t ra);
        logic aw_left;
        logic w_left;
        logic ar_left;
        aw_left = aw;
        w_left  = w;
        ar_left = ar;
        @(posedge clk);
        #1;
        awvalid = aw;
        awaddr  = a;
        wvalid  = w;
        wdata   = d;
        wstrb   = s;
        arvalid = ar;
        araddr  = ra;
        while (aw_left || w_left || ar_left) begin
            @(negedge clk);
            if (awvalid && awready) aw_left = 1'b0;
            if (wvalid && wready) w_left = 1'b0;
            if (arvalid && arready) ar_left = 1'b0;
            @(posedge clk);
            #1;
            if (!aw_left) awvalid = 1'b0;
            if (!w_left) wvalid = 1'b0;
            if (!ar_left) arvalid = 1'b0;
        end
    endtask

    task automatic set_ready(input int mode);
        @(negedge clk);
        ready_mode = mode;
    endtask

    task automatic count_valid_run(output int n);
        n = 0;
        while (!noc_valid) @(negedge clk);
        while (noc_valid) begin
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (kind_q.size() != 0 || exp_q.size() != 0 || noc_valid) @(negedge clk);
    endtask

    initial begin
        int n;
        int accepted;
        logic took;
        void'($urandom(32'h3ace));
        clk     = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        noc_ready  = 1'b0;
        ready_mode = 1;
        cycles     = 0;
        stall_q    = 1'b0;
        held_q     = '0;
        src_id     = 34'({$urandom, $urandom});
        dest_id    = 34'({$urandom, $urandom});
        test_name  = "reset";
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        assert (awready && wready && arready && !noc_valid)
        else fail_plain("ready lines or noc_valid wrong after reset");

        test_name = "single store";
        drive_request(1'b1, 1'b1, 1'b0, {$urandom, $urandom}, {$urandom, $urandom},
                      8'($urandom), '0);
        count_valid_run(n);
        assert (n == 4) else fail_value("valid cycles", 4, n);
        wait_drain();

        test_name = "single load";
        drive_request(1'b0, 1'b0, 1'b1, '0, '0, '0, {$urandom, $urandom});
        count_valid_run(n);
        assert (n == 3) else fail_value("valid cycles", 3, n);
        wait_drain();

        test_name = "joint write and read";
        drive_request(1'b1, 1'b1, 1'b1, {$urandom, $urandom}, {$urandom, $urandom},
                      8'($urandom), {$urandom, $urandom});
        @(negedge clk);
        assert (!awready && !arready)
        else fail_plain("awready or arready high on the cycle after a joint accept");
        count_valid_run(n);
        assert (n == 4) else fail_value("store valid cycles", 4, n);
        count_valid_run(n);
        assert (n == 3) else fail_value("load valid cycles", 3, n);
        wait_drain();

        test_name = "late write data";
        set_ready(2);
        drive_request(1'b1, 1'b0, 1'b0, {$urandom, $urandom}, '0, '0, '0);
        repeat (2) drive_request(1'b0, 1'b0, 1'b1, '0, '0, '0, {$urandom, $urandom});
        repeat (3) @(posedge clk);
        drive_request(1'b0, 1'b1, 1'b0, '0, {$urandom, $urandom}, 8'($urandom), '0);
        repeat (2) drive_request(1'b0, 1'b0, 1'b1, '0, '0, '0, {$urandom, $urandom});
        // mixed traffic under random back-pressure
        repeat (40) begin
            case ($urandom % 3)
                0: drive_request(1'b1, 1'b1, 1'b0, {$urandom, $urandom},
                                 {$urandom, $urandom}, 8'($urandom), '0);
                1: drive_request(1'b0, 1'b0, 1'b1, '0, '0, '0, {$urandom, $urandom});
                default: begin
                    drive_request(1'b1, 1'b0, 1'b0, {$urandom, $urandom}, '0, '0, '0);
                    drive_request(1'b0, 1'b1, 1'b0, '0, {$urandom, $urandom},
                                  8'($urandom), '0);
                end
            endcase
        end
        wait_drain();

        test_name = "read back-pressure";
        set_ready(0);
        accepted = 0;
        @(posedge clk);
        #1;
        arvalid = 1'b1;
        araddr  = {$urandom, $urandom};
        repeat (20) begin
            @(negedge clk);
            took = arready;
            if (took) accepted++;
            @(posedge clk);
            #1;
            if (took) araddr = {$urandom, $urandom};   // new address only after a handshake
        end
        arvalid = 1'b0;
        assert (accepted == 4) else fail_value("accepted reads", 4, accepted);
        set_ready(1);
        wait_drain();

        repeat (5) @(posedge clk);
        if (exp_q.size() == 0 && kind_q.size() == 0 && aw_q.size() == 0 &&
            w_q.size() == 0 && ar_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_plain("accepted requests were never sent on the NoC link");
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/axi_lite_pkg.sv
verilog/noc_pkg.sv
verilog/sync_fifo.sv
verilog/axi_request_queue.sv
verilog/flit_serializer.sv
verilog/axilite_noc_bridge.sv
bench/bridge_tb.sv
